//--- src.f
verilog/smem_pkg.sv
verilog/read_loader.sv
verilog/ext_lane.sv
verilog/occ_req_arbiter.sv
verilog/result_collector.sv
verilog/smem_top.sv
testbench/tb_smem_top.sv

//--- run.sh
#!/bin/sh
# build and run the smem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_smem_top -o tb_smem_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_smem_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0

//--- testbench/tb_smem_top.sv
module tb_smem_top;
	import smem_pkg::*;

	localparam int NUM_READS   = 40;
	localparam int TIMEOUT_CYC = NUM_READS * MAX_QLEN * 12 + 2000;

	logic              clk_32ui = 1'b0;
	logic              rst_n;
	logic              load_valid;
	logic [LOAD_W-1:0] load_data;
	batch_cnt_t        batch_size;
	logic              read_load_done;
	logic              dram_valid;
	dram_req_t         dram_req;
	logic              dram_get;
	dram_rsp_t         dram_rsp;
	logic              output_request;
	logic              output_permit;
	logic              output_valid;
	result_t           output_data;
	logic              output_finish;

	// --------------------
	// reference model
	base_t     bwt [BWT_LEN];
	int        occ [BWT_LEN+1][4];  // count of each base before a row
	int        l2 [4];
	read_rec_t reads [NUM_READS];
	int        exp_len [NUM_READS];
	int        exp_k [NUM_READS];
	int        exp_l [NUM_READS];
	int        trk_k [NUM_READS];   // interval of the next request
	int        trk_l [NUM_READS];
	int        trk_step [NUM_READS];
	bit        seen [NUM_READS];

	int        q_rn [$];            // outstanding dram requests
	int        q_addr_k [$];
	int        q_addr_l [$];
	int        q_due [$];

	int        cyc;
	int        err_cnt;
	int        out_cnt;
	int        fin_cnt;
	int        last_valid_cyc;
	bit        load_started;

	smem_top u_smem_top (
		.clk_32ui_i       (clk_32ui),
		.rst_n_i          (rst_n),
		.load_valid_i     (load_valid),
		.load_data_i      (load_data),
		.batch_size_i     (batch_size),
		.read_load_done_o (read_load_done),
		.dram_valid_o     (dram_valid),
		.dram_req_o       (dram_req),
		.dram_get_i       (dram_get),
		.dram_rsp_i       (dram_rsp),
		.output_request_o (output_request),
		.output_permit_i  (output_permit),
		.output_valid_o   (output_valid),
		.output_data_o    (output_data),
		.output_finish_o  (output_finish)
	);

	always #2 clk_32ui = ~clk_32ui;

	task automatic value_error(input string msg);
		err_cnt++;
		$display("FAILED @%0t: %s", $time, msg);
	endtask

	task automatic note_failure(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	function automatic int backward_step(input int row, input int c);
		return l2[c] + occ[row][c];
	endfunction

	function automatic int base_at(input read_rec_t rec, input int i);
		return int'(rec.bases[2*i +: 2]);
	endfunction

	// random bwt string, occurrence table and L2 counts
	task automatic build_index();
		for (int i = 0; i < BWT_LEN; i++)
			bwt[i] = base_t'($urandom % 4);
		for (int c = 0; c < 4; c++)
			occ[0][c] = 0;
		for (int i = 0; i < BWT_LEN; i++) begin
			for (int c = 0; c < 4; c++)
				occ[i+1][c] = occ[i][c] + ((int'(bwt[i]) == c) ? 1 : 0);
		end
		l2[0] = 0;
		for (int c = 1; c < 4; c++)
			l2[c] = l2[c-1] + occ[BWT_LEN][c-1];
	endtask

	// even reads walk LF from a random row, odd reads are random
	task automatic make_reads();
		int qlen;
		int row;
		int c;
		int k;
		int l;
		int nk;
		int nl;
		bit stopped;
		for (int rn = 0; rn < NUM_READS; rn++) begin
			qlen = 1 + int'($urandom % 32);
			row  = int'($urandom % BWT_LEN);
			reads[rn] = '0;
			reads[rn].read_num = read_num_t'(rn);
			reads[rn].qlen     = qlen_t'(qlen);
			for (int i = 0; i < qlen; i++) begin
				if (rn % 2 == 0) begin
					c   = int'(bwt[row]);
					row = backward_step(row, c);
				end else begin
					c = int'($urandom % 4);
				end
				reads[rn].bases[2*i +: 2] = base_t'(c);
			end
			k = 0;
			l = BWT_LEN;
			exp_len[rn] = 0;
			stopped = 1'b0;
			for (int i = 0; i < qlen && !stopped; i++) begin
				c  = base_at(reads[rn], i);
				nk = backward_step(k, c);
				nl = backward_step(l, c);
				if (nk < nl) begin
					k = nk;
					l = nl;
					exp_len[rn]++;
				end else begin
					stopped = 1'b1;     // empty interval, keep the old bounds
				end
			end
			exp_k[rn]    = k;
			exp_l[rn]    = l;
			trk_k[rn]    = 0;
			trk_l[rn]    = BWT_LEN;
			trk_step[rn] = 0;
			seen[rn]     = 1'b0;
		end
	endtask

	task automatic send_batch();
		l2_table_t hdr;
		for (int c = 0; c < 4; c++)
			hdr[c] = bwt_idx_t'(l2[c]);
		@(negedge clk_32ui);
		load_started = 1'b1;
		load_valid   = 1'b1;
		load_data    = LOAD_W'(hdr);
		for (int rn = 0; rn < NUM_READS; rn++) begin
			@(negedge clk_32ui);
			while ($urandom % 4 == 0) begin  // idle gap
				load_valid = 1'b0;
				@(negedge clk_32ui);
			end
			load_valid = 1'b1;
			load_data  = LOAD_W'(reads[rn]);
			#1;
			if (read_load_done)
				value_error("read_load_done_o high before the last read beat");
		end
		@(negedge clk_32ui);
		load_valid = 1'b0;
		load_data  = '0;
		#1;
		if (!read_load_done)
			value_error("read_load_done_o low after the last read beat");
	endtask

	// answer the oldest request that is due
	task automatic serve_dram();
		int pick;
		dram_rsp_t rsp;
		pick = -1;
		for (int i = 0; i < q_due.size(); i++) begin
			if (pick < 0 && q_due[i] <= cyc)
				pick = i;
		end
		dram_get = 1'b0;
		if (pick >= 0) begin
			rsp.read_num = read_num_t'(q_rn[pick]);
			for (int c = 0; c < 4; c++) begin
				rsp.cnt_k[c] = bwt_idx_t'(occ[q_addr_k[pick]][c]);
				rsp.cnt_l[c] = bwt_idx_t'(occ[q_addr_l[pick]][c]);
			end
			dram_rsp = rsp;
			dram_get = 1'b1;
			q_rn.delete(pick);
			q_addr_k.delete(pick);
			q_addr_l.delete(pick);
			q_due.delete(pick);
		end
	endtask

	task automatic check_cycle();
		int rn;
		int ak;
		int al;
		int c;
		result_t res;
		if (!load_started && (dram_valid || read_load_done || output_request || output_valid
				|| output_finish))
			value_error("control output high before the first load beat");
		if (dram_valid) begin
			rn = int'(dram_req.read_num);
			ak = int'(dram_req.addr_k);
			al = int'(dram_req.addr_l);
			if (rn >= NUM_READS) begin
				value_error($sformatf("dram request for unknown read %0d", rn));
			end else if (trk_step[rn] >= int'(reads[rn].qlen)) begin
				value_error($sformatf("read %0d requested more steps than its length", rn));
			end else begin
				if (ak != trk_k[rn] || al != trk_l[rn])
					value_error($sformatf("read %0d step %0d request [%0d,%0d), expected [%0d,%0d)",
						rn, trk_step[rn], ak, al, trk_k[rn], trk_l[rn]));
				c = base_at(reads[rn], trk_step[rn]);
				trk_k[rn] = backward_step(trk_k[rn], c);
				trk_l[rn] = backward_step(trk_l[rn], c);
				trk_step[rn]++;
			end
			if (ak < 0 || ak > BWT_LEN)
				ak = 0;
			if (al < 0 || al > BWT_LEN)
				al = 0;
			q_rn.push_back(rn);
			q_addr_k.push_back(ak);
			q_addr_l.push_back(al);
			q_due.push_back(cyc + 1 + int'($urandom % 8));  // 1..8 cycles later
		end
		if (output_valid) begin
			if (!output_permit)
				value_error("output_valid_o without output_permit_i");
			if (!output_request)
				value_error("output_valid_o without output_request_o");
			res = output_data;
			rn  = int'(res.read_num);
			if (rn >= NUM_READS) begin
				value_error($sformatf("result for unknown read %0d", rn));
			end else begin
				if (seen[rn])
					value_error($sformatf("read %0d returned twice", rn));
				seen[rn] = 1'b1;
				if (int'(res.match_len) != exp_len[rn] || int'(res.k) != exp_k[rn]
						|| int'(res.l) != exp_l[rn])
					value_error($sformatf("read %0d got len %0d [%0d,%0d), expected %0d [%0d,%0d)",
						rn, res.match_len, res.k, res.l, exp_len[rn], exp_k[rn], exp_l[rn]));
			end
			out_cnt++;
			last_valid_cyc = cyc;
		end
		if (output_finish) begin
			fin_cnt++;
			if (out_cnt != NUM_READS || last_valid_cyc != cyc - 1)
				value_error($sformatf("output_finish_o after %0d results", out_cnt));
		end
	endtask

	// --------------------
	// per cycle responder and monitor
	always @(negedge clk_32ui) begin
		serve_dram();
		output_permit = ($urandom % 3 != 0);
		#1;
		check_cycle();     // stable until the next rising edge
		cyc++;
	end

	initial begin
		void'($urandom(69));
		rst_n          = 1'b0;
		load_valid     = 1'b0;
		load_data      = '0;
		batch_size     = batch_cnt_t'(NUM_READS);
		dram_get       = 1'b0;
		dram_rsp       = '0;
		output_permit  = 1'b0;
		cyc            = 0;
		err_cnt        = 0;
		out_cnt        = 0;
		fin_cnt        = 0;
		last_valid_cyc = -10;
		load_started   = 1'b0;
		build_index();
		make_reads();
		repeat (3) @(negedge clk_32ui);
		rst_n = 1'b1;
		repeat (2) @(negedge clk_32ui);
		send_batch();
		wait (fin_cnt != 0);
		repeat (20) @(negedge clk_32ui);   // catch a second finish pulse
		if (out_cnt != NUM_READS)
			note_failure($sformatf("received %0d results instead of %0d", out_cnt, NUM_READS));
		for (int rn = 0; rn < NUM_READS; rn++) begin
			if (!seen[rn])
				note_failure($sformatf("no result came back for read %0d", rn));
		end
		if (fin_cnt != 1)
			note_failure($sformatf("output_finish_o pulsed %0d times", fin_cnt));
		if (read_load_done)
			note_failure("read_load_done_o still high after output_finish_o");
		$display("errors: %0d  results: %0d of %0d  finish pulses: %0d",
			err_cnt, out_cnt, NUM_READS, fin_cnt);
		if (err_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk_32ui);
		$display("timeout: batch not finished after %0d cycles, errors: %0d  results: %0d",
			TIMEOUT_CYC, err_cnt, out_cnt);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- verilog/smem_top.sv
module smem_top (
	input  logic                        clk_32ui_i,
	input  logic                        rst_n_i,

	// batch load
	input  logic                        load_valid_i,
	input  logic [smem_pkg::LOAD_W-1:0] load_data_i,
	input  smem_pkg::batch_cnt_t        batch_size_i,
	output logic                        read_load_done_o,

	// occurrence lookups
	output logic                        dram_valid_o,
	output smem_pkg::dram_req_t         dram_req_o,
	input  logic                        dram_get_i,
	input  smem_pkg::dram_rsp_t         dram_rsp_i,

	// results
	output logic                        output_request_o,
	input  logic                        output_permit_i,
	output logic                        output_valid_o,
	output smem_pkg::result_t           output_data_o,
	output logic                        output_finish_o
);
	import smem_pkg::*;

	logic [NUM_LANES-1:0] lane_idle;
	logic [NUM_LANES-1:0] assign_vec;
	logic [NUM_LANES-1:0] req_pending;
	logic [NUM_LANES-1:0] grant;
	logic [NUM_LANES-1:0] lane_done;
	logic [NUM_LANES-1:0] lane_ack;
	read_rec_t            read_rec;    // shared by all lanes
	l2_table_t            l2_table;
	dram_req_t            lane_req [NUM_LANES];
	result_t              lane_result [NUM_LANES];

	read_loader u_read_loader (
		.clk_32ui_i       (clk_32ui_i),
		.rst_n_i          (rst_n_i),
		.load_valid_i     (load_valid_i),
		.load_data_i      (load_data_i),
		.batch_size_i     (batch_size_i),
		.read_load_done_o (read_load_done_o),
		.output_finish_i  (output_finish_o),
		.lane_idle_i      (lane_idle),
		.assign_vec_o     (assign_vec),
		.read_rec_o       (read_rec),
		.l2_table_o       (l2_table)
	);

	// --------------------
	// lane array
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		ext_lane u_ext_lane (
			.clk_32ui_i    (clk_32ui_i),
			.rst_n_i       (rst_n_i),
			.assign_i      (assign_vec[g]),
			.read_rec_i    (read_rec),
			.l2_table_i    (l2_table),
			.idle_o        (lane_idle[g]),
			.req_pending_o (req_pending[g]),
			.req_o         (lane_req[g]),
			.grant_i       (grant[g]),
			.dram_get_i    (dram_get_i),
			.dram_rsp_i    (dram_rsp_i),    // broadcast, matched by read_num
			.done_o        (lane_done[g]),
			.result_o      (lane_result[g]),
			.ack_i         (lane_ack[g])
		);
	end

	occ_req_arbiter u_occ_req_arbiter (
		.clk_32ui_i    (clk_32ui_i),
		.rst_n_i       (rst_n_i),
		.req_pending_i (req_pending),
		.req_i         (lane_req),
		.grant_o       (grant),
		.dram_valid_o  (dram_valid_o),
		.dram_req_o    (dram_req_o)
	);

	result_collector u_result_collector (
		.clk_32ui_i       (clk_32ui_i),
		.rst_n_i          (rst_n_i),
		.batch_size_i     (batch_size_i),
		.done_i           (lane_done),
		.result_i         (lane_result),
		.ack_o            (lane_ack),
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_valid_o   (output_valid_o),
		.output_data_o    (output_data_o),
		.output_finish_o  (output_finish_o)
	);

endmodule

//--- verilog/result_collector.sv
module result_collector (
	input  logic                           clk_32ui_i,
	input  logic                           rst_n_i,
	input  smem_pkg::batch_cnt_t           batch_size_i,
	input  logic [smem_pkg::NUM_LANES-1:0] done_i,
	input  smem_pkg::result_t              result_i [smem_pkg::NUM_LANES],
	output logic [smem_pkg::NUM_LANES-1:0] ack_o,
	output logic                           output_request_o,
	input  logic                           output_permit_i,
	output logic                           output_valid_o,
	output smem_pkg::result_t              output_data_o,
	output logic                           output_finish_o
);
	import smem_pkg::*;

	lane_id_t   ptr_q;
	lane_id_t   sel;
	logic       buf_full_q;
	result_t    buf_q;
	batch_cnt_t out_cnt_q;      // results sent this batch
	logic       last_out;

	// only take a lane result into an empty buffer
	assign ack_o = buf_full_q ? '0 : rr_pick(done_i, ptr_q);
	assign sel   = lane_of(ack_o);

	assign output_request_o = buf_full_q;
	assign output_valid_o   = buf_full_q && output_permit_i;
	assign output_data_o    = buf_q;
	assign last_out         = (out_cnt_q + batch_cnt_t'(1) == batch_size_i);

	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ptr_q           <= '0;
			buf_full_q      <= 1'b0;
			out_cnt_q       <= '0;
			output_finish_o <= 1'b0;
		end else begin
			output_finish_o <= output_valid_o && last_out;
			if (output_valid_o) begin
				buf_full_q <= 1'b0;
				out_cnt_q  <= last_out ? '0 : out_cnt_q + batch_cnt_t'(1);
			end else if (|ack_o) begin
				buf_full_q <= 1'b1;
				ptr_q      <= lane_id_t'((int'(sel) + 1) % NUM_LANES);
			end
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (|ack_o)
			buf_q <= result_i[sel];
	end

	// a result only leaves under permit, and only once
	a_valid_permit: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		output_valid_o |-> output_permit_i ##1 !output_valid_o);

endmodule

//--- verilog/occ_req_arbiter.sv
module occ_req_arbiter (
	input  logic                           clk_32ui_i,
	input  logic                           rst_n_i,
	input  logic [smem_pkg::NUM_LANES-1:0] req_pending_i,
	input  smem_pkg::dram_req_t            req_i [smem_pkg::NUM_LANES],
	output logic [smem_pkg::NUM_LANES-1:0] grant_o,
	output logic                           dram_valid_o,
	output smem_pkg::dram_req_t            dram_req_o
);
	import smem_pkg::*;

	lane_id_t ptr_q;    // first lane to look at
	lane_id_t sel;

	assign grant_o = rr_pick(req_pending_i, ptr_q);
	assign sel     = lane_of(grant_o);

	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ptr_q        <= '0;
			dram_valid_o <= 1'b0;
		end else begin
			dram_valid_o <= |grant_o;   // one strobe per grant
			if (|grant_o)
				ptr_q <= lane_id_t'((int'(sel) + 1) % NUM_LANES);
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (|grant_o)
			dram_req_o <= req_i[sel];
	end

	// --------------------
	// checks
	a_grant_onehot: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		$onehot0(grant_o) && ((grant_o & ~req_pending_i) == '0));

endmodule

//--- verilog/ext_lane.sv
module ext_lane (
	input  logic                clk_32ui_i,
	input  logic                rst_n_i,
	input  logic                assign_i,
	input  smem_pkg::read_rec_t read_rec_i,
	input  smem_pkg::l2_table_t l2_table_i,
	output logic                idle_o,
	output logic                req_pending_o,
	output smem_pkg::dram_req_t req_o,
	input  logic                grant_i,
	input  logic                dram_get_i,
	input  smem_pkg::dram_rsp_t dram_rsp_i,
	output logic                done_o,
	output smem_pkg::result_t   result_o,
	input  logic                ack_i
);
	import smem_pkg::*;

	lane_state_t state_q;
	read_num_t   read_num_q;
	logic [63:0] bases_q;
	qlen_t       qlen_q;
	qlen_t       step_q;        // accepted steps, also match_len
	bwt_idx_t    k_q;
	bwt_idx_t    l_q;

	qlen_t       qlen_in;
	base_t       cur_base;
	bwt_idx_t    new_k;
	bwt_idx_t    new_l;
	logic        rsp_hit;
	logic        step_ok;
	logic        step_last;

	assign qlen_in = (read_rec_i.qlen > qlen_t'(MAX_QLEN)) ? qlen_t'(MAX_QLEN) : read_rec_i.qlen;

	// --------------------
	// extension step
	assign cur_base  = base_t'(bases_q >> {step_q, 1'b0});
	assign new_k     = l2_table_i[cur_base] + dram_rsp_i.cnt_k[cur_base];
	assign new_l     = l2_table_i[cur_base] + dram_rsp_i.cnt_l[cur_base];
	assign rsp_hit   = dram_get_i && (state_q == LANE_WAIT) && (dram_rsp_i.read_num == read_num_q);
	assign step_ok   = new_k < new_l;   // interval still non-empty
	assign step_last = (step_q + qlen_t'(1) == qlen_q);

	assign idle_o        = state_q == LANE_IDLE;
	assign req_pending_o = state_q == LANE_REQ;
	assign done_o        = state_q == LANE_DONE;
	assign req_o         = '{read_num: read_num_q, addr_k: k_q, addr_l: l_q};
	assign result_o      = '{read_num: read_num_q, match_len: step_q, k: k_q, l: l_q, pad: '0};

	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= LANE_IDLE;
		end else begin
			case (state_q)
				LANE_IDLE: if (assign_i)
					state_q <= (qlen_in == '0) ? LANE_DONE : LANE_REQ;
				LANE_REQ: if (grant_i)
					state_q <= LANE_WAIT;
				LANE_WAIT: if (rsp_hit)
					state_q <= (step_ok && !step_last) ? LANE_REQ : LANE_DONE;
				LANE_DONE: if (ack_i)
					state_q <= LANE_IDLE;
				default: state_q <= LANE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (state_q == LANE_IDLE && assign_i) begin
			read_num_q <= read_rec_i.read_num;
			bases_q    <= read_rec_i.bases;
			qlen_q     <= qlen_in;
			step_q     <= '0;
			k_q        <= '0;
			l_q        <= bwt_idx_t'(BWT_LEN);   // whole text
		end else if (rsp_hit && step_ok) begin
			step_q <= step_q + qlen_t'(1);
			k_q    <= new_k;
			l_q    <= new_l;
		end
	end

	// a granted request drops at once and the lane sits in wait
	a_grant_then_wait: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		grant_i |-> req_pending_o ##1 (state_q == LANE_WAIT && !req_pending_o));

endmodule

//--- verilog/read_loader.sv
module read_loader (
	input  logic                           clk_32ui_i,
	input  logic                           rst_n_i,
	input  logic                           load_valid_i,
	input  logic [smem_pkg::LOAD_W-1:0]    load_data_i,
	input  smem_pkg::batch_cnt_t           batch_size_i,
	output logic                           read_load_done_o,
	input  logic                           output_finish_i,
	input  logic [smem_pkg::NUM_LANES-1:0] lane_idle_i,
	output logic [smem_pkg::NUM_LANES-1:0] assign_vec_o,
	output smem_pkg::read_rec_t            read_rec_o,
	output smem_pkg::l2_table_t            l2_table_o
);
	import smem_pkg::*;

	read_rec_t  rec_mem [READ_DEPTH];
	batch_cnt_t wr_cnt_q;       // records stored
	batch_cnt_t rd_cnt_q;       // records dispatched
	logic       hdr_wait_q;     // next beat is the L2 header
	logic       rec_we;
	logic       avail;

	assign rec_we = load_valid_i && !hdr_wait_q && (wr_cnt_q < batch_size_i);
	assign avail  = !hdr_wait_q && (rd_cnt_q < wr_cnt_q);

	// lowest idle lane gets the oldest undispatched read
	assign assign_vec_o = avail ? rr_pick(lane_idle_i, lane_id_t'(0)) : '0;
	assign read_rec_o   = rec_mem[rd_cnt_q[READ_AW-1:0]];

	always_ff @(posedge clk_32ui_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hdr_wait_q       <= 1'b1;
			read_load_done_o <= 1'b0;
			wr_cnt_q         <= '0;
			rd_cnt_q         <= '0;
		end else if (output_finish_i) begin
			// batch drained, wait for a new header
			hdr_wait_q       <= 1'b1;
			read_load_done_o <= 1'b0;
			wr_cnt_q         <= '0;
			rd_cnt_q         <= '0;
		end else begin
			if (load_valid_i && hdr_wait_q)
				hdr_wait_q <= 1'b0;
			if (rec_we) begin
				wr_cnt_q <= wr_cnt_q + batch_cnt_t'(1);
				if (wr_cnt_q + batch_cnt_t'(1) == batch_size_i)
					read_load_done_o <= 1'b1;   // last read beat
			end
			if (|assign_vec_o)
				rd_cnt_q <= rd_cnt_q + batch_cnt_t'(1);
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (load_valid_i && hdr_wait_q)
			l2_table_o <= l2_table_t'(load_data_i);
	end

	always_ff @(posedge clk_32ui_i) begin
		if (rec_we)
			rec_mem[wr_cnt_q[READ_AW-1:0]] <= read_rec_t'(load_data_i[$bits(read_rec_t)-1:0]);
	end

	// a read only ever goes to one lane, and that lane must be idle
	a_assign_onehot_idle: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		$onehot0(assign_vec_o) && ((assign_vec_o & ~lane_idle_i) == '0));

endmodule

//--- verilog/smem_pkg.sv
package smem_pkg;

	// --------------------
	// sizes
	localparam int NUM_LANES  = 4;
	localparam int BWT_LEN    = 1024;   // initial interval is [0, BWT_LEN)
	localparam int MAX_QLEN   = 32;
	localparam int LOAD_W     = 128;
	localparam int READ_DEPTH = 128;    // read records held per batch
	localparam int READ_AW    = $clog2(READ_DEPTH);

	// --------------------
	// scalar types
	typedef logic [1:0]  base_t;        // A C G T = 0..3
	typedef logic [31:0] bwt_idx_t;
	typedef logic [7:0]  read_num_t;
	typedef logic [8:0]  batch_cnt_t;   // read_num plus one bit
	typedef logic [5:0]  qlen_t;
	typedef logic [1:0]  lane_id_t;

	typedef bwt_idx_t [3:0] l2_table_t; // indexed by base
	typedef bwt_idx_t [3:0] occ_row_t;

	// --------------------
	// records
	typedef struct packed {
		read_num_t   read_num;
		qlen_t       qlen;
		logic [63:0] bases;             // base 0 in bits 1:0
	} read_rec_t;

	typedef struct packed {
		read_num_t read_num;
		bwt_idx_t  addr_k;
		bwt_idx_t  addr_l;
	} dram_req_t;

	typedef struct packed {
		read_num_t read_num;
		occ_row_t  cnt_k;
		occ_row_t  cnt_l;
	} dram_rsp_t;

	typedef struct packed {
		read_num_t   read_num;
		qlen_t       match_len;
		bwt_idx_t    k;
		bwt_idx_t    l;
		logic [49:0] pad;               // fills one 128 bit beat
	} result_t;

	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_REQ,
		LANE_WAIT,
		LANE_DONE
	} lane_state_t;

	// first requester at or after ptr, one-hot
	function automatic logic [NUM_LANES-1:0] rr_pick(input logic [NUM_LANES-1:0] req,
		input lane_id_t ptr);
		logic [NUM_LANES-1:0] gnt;
		lane_id_t             idx;
		gnt = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			idx = lane_id_t'((int'(ptr) + i) % NUM_LANES);
			if (req[idx] && gnt == '0)
				gnt[idx] = 1'b1;
		end
		return gnt;
	endfunction

	function automatic lane_id_t lane_of(input logic [NUM_LANES-1:0] vec);
		lane_id_t id;
		id = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (vec[i])
				id = lane_id_t'(i);
		end
		return id;
	endfunction

endpackage
